/* filelist.f */
rs_pkg.sv
rs_alloc_steer.sv
rs_entry_bank.sv
rs_issue_select.sv
reservation_station.sv
rs_checker.sv
tb_reservation_station.sv

/* reservation_station.sv */
`timescale 1ns/100ps

module reservation_station (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            allocate,
    input  rs_pkg::rs_packet_t              in_packet,
    output logic                            done,
    input  logic                            update,
    input  rs_pkg::preg_tag_t               cdb_tag,
    input  logic                            issue_enable,
    output rs_pkg::rs_packet_t              issued_packet,
    output rs_pkg::slot_t                   issue_slot,
    output logic                            alu_full,
    output logic                            mult_full,
    output logic                            mem_full,
    input  logic [rs_pkg::ALU_ENTRIES-1:0]  free_alu,
    input  logic [rs_pkg::MULT_ENTRIES-1:0] free_mult,
    input  logic [rs_pkg::MEM_ENTRIES-1:0]  free_mem
);
    import rs_pkg::*;

    logic       alu_alloc;
    logic       mult_alloc;
    logic       mem_alloc;
    logic       alu_grant;
    logic       mult_grant;
    logic       mem_grant;
    logic       alu_cand_valid;
    logic       mult_cand_valid;
    logic       mem_cand_valid;
    rs_packet_t alu_cand_packet;
    rs_packet_t mult_cand_packet;
    rs_packet_t mem_cand_packet;
    slot_t      alu_cand_slot;
    slot_t      mult_cand_slot;
    slot_t      mem_cand_slot;

    rs_alloc_steer alloc_steer_i (
        .clock     (clock),
        .reset     (reset),
        .allocate  (allocate),
        .in_class  (in_packet.fu_class),
        .alu_full  (alu_full),
        .mult_full (mult_full),
        .mem_full  (mem_full),
        .alu_alloc (alu_alloc),
        .mult_alloc(mult_alloc),
        .mem_alloc (mem_alloc),
        .done      (done)
    );

    rs_entry_bank #(.num_entries(ALU_ENTRIES)) alu_bank_i (
        .clock      (clock),
        .reset      (reset),
        .alloc      (alu_alloc),
        .in_packet  (in_packet),
        .update     (update),
        .cdb_tag    (cdb_tag),
        .grant      (alu_grant),
        .free       (free_alu),
        .full       (alu_full),
        .cand_valid (alu_cand_valid),
        .cand_packet(alu_cand_packet),
        .cand_slot  (alu_cand_slot)
    );

    rs_entry_bank #(.num_entries(MULT_ENTRIES)) mult_bank_i (
        .clock      (clock),
        .reset      (reset),
        .alloc      (mult_alloc),
        .in_packet  (in_packet),
        .update     (update),
        .cdb_tag    (cdb_tag),
        .grant      (mult_grant),
        .free       (free_mult),
        .full       (mult_full),
        .cand_valid (mult_cand_valid),
        .cand_packet(mult_cand_packet),
        .cand_slot  (mult_cand_slot)
    );

    rs_entry_bank #(.num_entries(MEM_ENTRIES)) mem_bank_i (
        .clock      (clock),
        .reset      (reset),
        .alloc      (mem_alloc),
        .in_packet  (in_packet),
        .update     (update),
        .cdb_tag    (cdb_tag),
        .grant      (mem_grant),
        .free       (free_mem),
        .full       (mem_full),
        .cand_valid (mem_cand_valid),
        .cand_packet(mem_cand_packet),
        .cand_slot  (mem_cand_slot)
    );

    rs_issue_select issue_select_i (
        .clock           (clock),
        .reset           (reset),
        .issue_enable    (issue_enable),
        .alu_cand_valid  (alu_cand_valid),
        .mult_cand_valid (mult_cand_valid),
        .mem_cand_valid  (mem_cand_valid),
        .alu_cand_packet (alu_cand_packet),
        .mult_cand_packet(mult_cand_packet),
        .mem_cand_packet (mem_cand_packet),
        .alu_cand_slot   (alu_cand_slot),
        .mult_cand_slot  (mult_cand_slot),
        .mem_cand_slot   (mem_cand_slot),
        .alu_grant       (alu_grant),
        .mult_grant      (mult_grant),
        .mem_grant       (mem_grant),
        .issued_packet   (issued_packet),
        .issue_slot      (issue_slot)
    );

endmodule

/* rs_alloc_steer.sv */
`timescale 1ns/100ps

module rs_alloc_steer (
    input  logic              clock,
    input  logic              reset,
    input  logic              allocate,
    input  rs_pkg::fu_class_e in_class,
    input  logic              alu_full,
    input  logic              mult_full,
    input  logic              mem_full,
    output logic              alu_alloc,
    output logic              mult_alloc,
    output logic              mem_alloc,
    output logic              done
);
    import rs_pkg::*;

    // class decode, then gate with the target bank's full flag
    always_comb begin
        alu_alloc  = 1'b0;
        mult_alloc = 1'b0;
        mem_alloc  = 1'b0;
        if (allocate) begin
            case (in_class)
                FU_ALU:  alu_alloc  = !alu_full;
                FU_MULT: mult_alloc = !mult_full;
                FU_MEM:  mem_alloc  = !mem_full;
                // unused encoding is dropped like a full bank
                default: ;
            endcase
        end
    end

    // done follows an accepted allocate by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= alu_alloc | mult_alloc | mem_alloc;
        end
    end

    // a packet lands in one bank at most
    a_alloc_onehot: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({alu_alloc, mult_alloc, mem_alloc})
    ) else $error("more than one bank allocated in the same cycle");

endmodule

/* rs_checker.sv */
`timescale 1ns/100ps

module rs_checker (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            allocate,
    input  rs_pkg::rs_packet_t              in_packet,
    input  logic                            update,
    input  rs_pkg::preg_tag_t               cdb_tag,
    input  logic                            issue_enable,
    input  logic [rs_pkg::ALU_ENTRIES-1:0]  free_alu,
    input  logic [rs_pkg::MULT_ENTRIES-1:0] free_mult,
    input  logic [rs_pkg::MEM_ENTRIES-1:0]  free_mem,
    input  logic                            done,
    input  rs_pkg::rs_packet_t              issued_packet,
    input  rs_pkg::slot_t                   issue_slot,
    input  logic                            alu_full,
    input  logic                            mult_full,
    input  logic                            mem_full,
    output int                              mismatch_count
);
    import rs_pkg::*;

    typedef struct packed {
        logic       busy;
        logic       issued;
        rs_packet_t packet;
    } model_entry_t;

    // class index 0 ALU, 1 MULT, 2 MEM
    model_entry_t model [3][MAX_ENTRIES];
    logic         exp_done;
    rs_packet_t   exp_packet;
    slot_t        exp_slot;

    function automatic int depth_of(input int c);
        if (c == 0) return ALU_ENTRIES;
        if (c == 1) return MULT_ENTRIES;
        return MEM_ENTRIES;
    endfunction

    function automatic logic bank_full(input int c);
        logic all_busy;
        all_busy = 1'b1;
        for (int s = 0; s < depth_of(c); s++) begin
            all_busy = all_busy & model[c][s].busy;
        end
        return all_busy;
    endfunction

    function automatic logic dut_full(input int c);
        if (c == 0) return alu_full;
        if (c == 1) return mult_full;
        return mem_full;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        mismatch_count++;
    endtask

    always @(posedge clock) begin : model_step
        logic                   full_now [3];
        logic                   cand_ok [3];
        int                     cand_idx [3];
        logic [MAX_ENTRIES-1:0] free_vec [3];
        int                     alloc_cls;
        int                     alloc_idx;
        int                     pick;
        rs_packet_t             new_packet;

        if (reset) begin
            for (int c = 0; c < 3; c++) begin
                for (int s = 0; s < MAX_ENTRIES; s++) begin
                    model[c][s] = '0;
                end
            end
            exp_done       = 1'b0;
            exp_packet     = '0;
            exp_slot       = '0;
            mismatch_count = 0;
        end else begin
            // outputs still show the state from before this edge
            if (done !== exp_done) begin
                report_mismatch($sformatf("done is %0b, expected %0b", done, exp_done));
            end
            for (int c = 0; c < 3; c++) begin
                full_now[c] = bank_full(c);
                if (dut_full(c) !== full_now[c]) begin
                    report_mismatch($sformatf("full flag of class %0d is %0b, expected %0b",
                                              c, dut_full(c), full_now[c]));
                end
            end
            if (issued_packet.valid !== exp_packet.valid) begin
                report_mismatch($sformatf("issue valid is %0b, expected %0b",
                                          issued_packet.valid, exp_packet.valid));
            end else if (exp_packet.valid &&
                         (issued_packet !== exp_packet || issue_slot !== exp_slot)) begin
                report_mismatch($sformatf("issued %h in slot %0d, expected %h in slot %0d",
                                          issued_packet, issue_slot, exp_packet, exp_slot));
            end else if (!exp_packet.valid && issue_slot !== '0) begin
                report_mismatch($sformatf("idle issue slot is %0d, expected 0", issue_slot));
            end

            // highest ready slot per bank
            for (int c = 0; c < 3; c++) begin
                cand_ok[c]  = 1'b0;
                cand_idx[c] = 0;
                for (int s = 0; s < depth_of(c); s++) begin
                    if (model[c][s].busy && !model[c][s].issued &&
                        model[c][s].packet.src1.ready && model[c][s].packet.src2.ready) begin
                        cand_ok[c]  = 1'b1;
                        cand_idx[c] = s;
                    end
                end
            end

            // ALU first, then MULT, then MEM
            pick = -1;
            if (issue_enable) begin
                for (int c = 2; c >= 0; c--) begin
                    if (cand_ok[c]) pick = c;
                end
            end
            exp_packet = '0;
            exp_slot   = '0;
            if (pick >= 0) begin
                exp_packet       = model[pick][cand_idx[pick]].packet;
                exp_packet.valid = 1'b1;
                exp_slot         = slot_t'(cand_idx[pick]);
            end

            // lowest free slot of the target bank
            alloc_cls = int'(in_packet.fu_class);
            alloc_idx = -1;
            exp_done  = 1'b0;
            if (allocate && alloc_cls < 3) begin
                if (!full_now[alloc_cls]) begin
                    exp_done = 1'b1;
                    for (int s = depth_of(alloc_cls) - 1; s >= 0; s--) begin
                        if (!model[alloc_cls][s].busy) alloc_idx = s;
                    end
                end
            end

            if (update) begin
                for (int c = 0; c < 3; c++) begin
                    for (int s = 0; s < depth_of(c); s++) begin
                        if (model[c][s].packet.src1.tag == cdb_tag) begin
                            model[c][s].packet.src1.ready = 1'b1;
                        end
                        if (model[c][s].packet.src2.tag == cdb_tag) begin
                            model[c][s].packet.src2.ready = 1'b1;
                        end
                    end
                end
            end
            if (pick >= 0) begin
                model[pick][cand_idx[pick]].issued = 1'b1;
            end
            free_vec[0] = MAX_ENTRIES'(free_alu);
            free_vec[1] = MAX_ENTRIES'(free_mult);
            free_vec[2] = MAX_ENTRIES'(free_mem);
            for (int c = 0; c < 3; c++) begin
                for (int s = 0; s < depth_of(c); s++) begin
                    if (free_vec[c][s]) model[c][s].busy = 1'b0;
                end
            end
            if (exp_done) begin
                // a same-cycle broadcast counts for the new entry too
                new_packet = in_packet;
                if (update && in_packet.src1.tag == cdb_tag) new_packet.src1.ready = 1'b1;
                if (update && in_packet.src2.tag == cdb_tag) new_packet.src2.ready = 1'b1;
                model[alloc_cls][alloc_idx].busy   = 1'b1;
                model[alloc_cls][alloc_idx].issued = 1'b0;
                model[alloc_cls][alloc_idx].packet = new_packet;
            end
        end
    end

endmodule

/* rs_entry_bank.sv */
`timescale 1ns/100ps

module rs_entry_bank #(
    parameter int num_entries = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   alloc,
    input  rs_pkg::rs_packet_t     in_packet,
    input  logic                   update,
    input  rs_pkg::preg_tag_t      cdb_tag,
    input  logic                   grant,
    input  logic [num_entries-1:0] free,
    output logic                   full,
    output logic                   cand_valid,
    output rs_pkg::rs_packet_t     cand_packet,
    output rs_pkg::slot_t          cand_slot
);
    import rs_pkg::*;

    // one reservation entry
    typedef struct packed {
        logic       busy;
        logic       issued;
        rs_packet_t packet;
    } rs_entry_t;

    rs_entry_t              entries [num_entries];
    logic [num_entries-1:0] busy_vec;
    logic                   free_found;
    int                     free_idx;
    int                     cand_idx;
    rs_packet_t             alloc_packet;

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            busy_vec[i] = entries[i].busy;
        end
    end

    assign full = &busy_vec;

    // scan downward so the lowest free index is the one left standing
    always_comb begin
        free_found = 1'b0;
        free_idx   = 0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                free_found = 1'b1;
                free_idx   = i;
            end
        end
    end

    // same-cycle CDB broadcast folded into the incoming packet
    always_comb begin
        alloc_packet = in_packet;
        if (update && (in_packet.src1.tag == cdb_tag)) begin
            alloc_packet.src1.ready = 1'b1;
        end
        if (update && (in_packet.src2.tag == cdb_tag)) begin
            alloc_packet.src2.ready = 1'b1;
        end
    end

    // highest ready index wins the issue
    always_comb begin
        cand_valid = 1'b0;
        cand_idx   = 0;
        for (int i = 0; i < num_entries; i++) begin
            if (entries[i].busy && !entries[i].issued &&
                entries[i].packet.src1.ready && entries[i].packet.src2.ready) begin
                cand_valid = 1'b1;
                cand_idx   = i;
            end
        end
    end

    assign cand_slot   = slot_t'(cand_idx);
    assign cand_packet = entries[cand_idx].packet;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_entries; i++) begin
                entries[i].busy   <= 1'b0;
                entries[i].issued <= 1'b0;
            end
        end else begin
            // wakeup on stored operands
            if (update) begin
                for (int i = 0; i < num_entries; i++) begin
                    if (entries[i].packet.src1.tag == cdb_tag) begin
                        entries[i].packet.src1.ready <= 1'b1;
                    end
                    if (entries[i].packet.src2.tag == cdb_tag) begin
                        entries[i].packet.src2.ready <= 1'b1;
                    end
                end
            end

            // granted entry stays busy until its FU frees it
            if (grant) begin
                entries[cand_idx].issued <= 1'b1;
            end

            for (int i = 0; i < num_entries; i++) begin
                if (free[i]) begin
                    entries[i].busy <= 1'b0;
                end
            end

            // written last to override the wakeup on the same slot
            if (alloc && free_found) begin
                entries[free_idx].busy   <= 1'b1;
                entries[free_idx].issued <= 1'b0;
                entries[free_idx].packet <= alloc_packet;
            end
        end
    end

    // steerer must hold off a full bank
    a_no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset)
        alloc |-> !full
    ) else $error("allocate strobe into a full bank");

    // FU side only releases slots it was handed
    a_free_hits_busy: assert property (
        @(posedge clock) disable iff (reset)
        (free & ~busy_vec) == '0
    ) else $error("free bit on a slot that is not busy");

    a_grant_has_cand: assert property (
        @(posedge clock) disable iff (reset)
        grant |-> cand_valid
    ) else $error("grant without a ready candidate");

endmodule

/* rs_issue_select.sv */
`timescale 1ns/100ps

module rs_issue_select (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_enable,
    input  logic               alu_cand_valid,
    input  logic               mult_cand_valid,
    input  logic               mem_cand_valid,
    input  rs_pkg::rs_packet_t alu_cand_packet,
    input  rs_pkg::rs_packet_t mult_cand_packet,
    input  rs_pkg::rs_packet_t mem_cand_packet,
    input  rs_pkg::slot_t      alu_cand_slot,
    input  rs_pkg::slot_t      mult_cand_slot,
    input  rs_pkg::slot_t      mem_cand_slot,
    output logic               alu_grant,
    output logic               mult_grant,
    output logic               mem_grant,
    output rs_pkg::rs_packet_t issued_packet,
    output rs_pkg::slot_t      issue_slot
);
    import rs_pkg::*;

    rs_packet_t sel_packet;
    slot_t      sel_slot;

    // fixed priority ALU > MULT > MEM
    always_comb begin
        alu_grant  = 1'b0;
        mult_grant = 1'b0;
        mem_grant  = 1'b0;
        sel_packet = '0;
        sel_slot   = '0;
        if (issue_enable) begin
            if (alu_cand_valid) begin
                alu_grant  = 1'b1;
                sel_packet = alu_cand_packet;
                sel_slot   = alu_cand_slot;
            end else if (mult_cand_valid) begin
                mult_grant = 1'b1;
                sel_packet = mult_cand_packet;
                sel_slot   = mult_cand_slot;
            end else if (mem_cand_valid) begin
                mem_grant  = 1'b1;
                sel_packet = mem_cand_packet;
                sel_slot   = mem_cand_slot;
            end
            // issued packet is always marked valid
            if (alu_grant || mult_grant || mem_grant) begin
                sel_packet.valid = 1'b1;
            end
        end
    end

    // issue register, zero when nothing was granted
    always_ff @(posedge clock) begin
        if (reset) begin
            issued_packet <= '0;
            issue_slot    <= '0;
        end else begin
            issued_packet <= sel_packet;
            issue_slot    <= sel_slot;
        end
    end

    // one issue per cycle across all banks
    a_grant_onehot: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({alu_grant, mult_grant, mem_grant})
    ) else $error("more than one bank granted in the same cycle");

endmodule

/* rs_pkg.sv */
package rs_pkg;

    // physical register file has 64 entries
    localparam int PREG_W = 6;

    // bank depths, one bank per functional-unit class
    localparam int ALU_ENTRIES  = 4;
    localparam int MULT_ENTRIES = 2;
    localparam int MEM_ENTRIES  = 4;

    // deepest bank sets the slot index width
    localparam int MAX_ENTRIES =
        (ALU_ENTRIES > MULT_ENTRIES) ?
            ((ALU_ENTRIES > MEM_ENTRIES) ? ALU_ENTRIES : MEM_ENTRIES) :
            ((MULT_ENTRIES > MEM_ENTRIES) ? MULT_ENTRIES : MEM_ENTRIES);
    localparam int SLOT_W = (MAX_ENTRIES > 1) ? $clog2(MAX_ENTRIES) : 1;

    localparam int INSN_ID_W = 10;

    typedef logic [PREG_W-1:0] preg_tag_t;

    typedef logic [SLOT_W-1:0] slot_t;

    // source operand, ready once its producer has broadcast the tag
    typedef struct packed {
        preg_tag_t tag;
        logic      ready;
    } operand_t;

    // functional-unit class, selects the bank
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MULT = 2'd1,
        FU_MEM  = 2'd2
    } fu_class_e;

    // one instruction as it moves from dispatch to issue
    typedef struct packed {
        logic                 valid;
        fu_class_e            fu_class;
        preg_tag_t            dest_tag;
        operand_t             src1;
        operand_t             src2;
        // opaque id, carried through untouched
        logic [INSN_ID_W-1:0] insn_id;
    } rs_packet_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_reservation_station -o tb_reservation_station \
    && ./obj_dir/tb_reservation_station | tee sim.log \
    || echo "build or simulation did not complete"

grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_reservation_station.sv */
`timescale 1ns/100ps

module tb_reservation_station;
    import rs_pkg::*;

    localparam int RUN_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 60;

    logic                    clock;
    logic                    reset;
    logic                    allocate;
    rs_packet_t              in_packet;
    logic                    done;
    logic                    update;
    preg_tag_t               cdb_tag;
    logic                    issue_enable;
    rs_packet_t              issued_packet;
    slot_t                   issue_slot;
    logic                    alu_full;
    logic                    mult_full;
    logic                    mem_full;
    logic [ALU_ENTRIES-1:0]  free_alu;
    logic [MULT_ENTRIES-1:0] free_mult;
    logic [MEM_ENTRIES-1:0]  free_mem;
    int                      mismatch_count;
    int                      timeout_count;
    int                      drain_cycles;
    integer                  seed = 32'h9861e671;
    // cycles left until the FU releases each issued slot, 0 when idle
    int                      free_delay [3][MAX_ENTRIES];

    reservation_station reservation_station_i (.*);

    rs_checker check_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic int random_below(input int bound);
        return int'($unsigned($random(seed)) % bound);
    endfunction

    function automatic bit chance(input int pct);
        return random_below(100) < pct;
    endfunction

    function automatic int pending_frees();
        int count;
        count = 0;
        for (int c = 0; c < 3; c++) begin
            for (int s = 0; s < MAX_ENTRIES; s++) begin
                if (free_delay[c][s] > 0) count++;
            end
        end
        return count;
    endfunction

    // one falling edge worth of inputs; no new work when traffic is low
    task automatic drive_stimulus(input bit traffic);
        logic [MAX_ENTRIES-1:0] free_bits [3];
        for (int c = 0; c < 3; c++) begin
            free_bits[c] = '0;
            for (int s = 0; s < MAX_ENTRIES; s++) begin
                if (free_delay[c][s] > 0) begin
                    free_delay[c][s]--;
                    if (free_delay[c][s] == 0) free_bits[c][s] = 1'b1;
                end
            end
        end
        if (issued_packet.valid) begin
            free_delay[int'(issued_packet.fu_class)][issue_slot] = 1 + random_below(6);
        end
        free_alu  = free_bits[0][ALU_ENTRIES-1:0];
        free_mult = free_bits[1][MULT_ENTRIES-1:0];
        free_mem  = free_bits[2][MEM_ENTRIES-1:0];

        allocate              = traffic && chance(50);
        in_packet.valid       = allocate;
        in_packet.fu_class    = fu_class_e'(random_below(3));
        in_packet.dest_tag    = preg_tag_t'($random(seed));
        // small tag pool so broadcasts actually hit waiting sources
        in_packet.src1.tag    = preg_tag_t'(random_below(8));
        in_packet.src1.ready  = chance(40);
        in_packet.src2.tag    = preg_tag_t'(random_below(8));
        in_packet.src2.ready  = chance(40);
        in_packet.insn_id     = INSN_ID_W'($random(seed));
        update                = traffic && chance(40);
        cdb_tag               = preg_tag_t'(random_below(8));
        issue_enable          = !traffic || chance(70);
    endtask

    initial begin
        reset         = 1'b1;
        allocate      = 1'b0;
        in_packet     = '0;
        update        = 1'b0;
        cdb_tag       = '0;
        issue_enable  = 1'b0;
        free_alu      = '0;
        free_mult     = '0;
        free_mem      = '0;
        timeout_count = 0;
        for (int c = 0; c < 3; c++) begin
            for (int s = 0; s < MAX_ENTRIES; s++) free_delay[c][s] = 0;
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;

        for (int n = 0; n < RUN_CYCLES; n++) begin
            drive_stimulus(1'b1);
            @(negedge clock);
        end

        // quiet phase, wait for every issued slot to be released
        drain_cycles = 0;
        while ((pending_frees() > 0 || issued_packet.valid) && drain_cycles < DRAIN_LIMIT) begin
            drive_stimulus(1'b0);
            @(negedge clock);
            drain_cycles++;
        end
        if (pending_frees() > 0 || issued_packet.valid) begin
            $display("Timeout: issued slots were not all freed within %0d cycles", DRAIN_LIMIT);
            timeout_count++;
        end
        free_alu     = '0;
        free_mult    = '0;
        free_mem     = '0;
        issue_enable = 1'b0;
        repeat (2) @(negedge clock);

        $display("mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
